//--- all.f
+incdir+include
source/scom_proto_pkg.sv
source/scom_bus_pkg.sv
source/scom_frame_ctrl.sv
source/scom_head_shifter.sv
source/scom_data_shifter.sv
source/scom_satellite.sv
verif/scom_clk_gen.sv
verif/tb_scom_satellite.sv

//--- include/scom_config.svh
// SCOM satellite configuration
// Field widths, data word geometry and the bit counter checkpoints of a frame
`ifndef SCOM_CONFIG_SVH
`define SCOM_CONFIG_SVH

`define SCOM_SATID_BITS 4
`define SCOM_REGID_BITS 6
`define SCOM_DATA_BITS 64
`define SCOM_PAR_GROUP 16
`define SCOM_PAR_BITS 4
`define SCOM_CNT_BITS 7
// Start bit, satellite id, register id, read/not-write and header parity
`define SCOM_HEAD_BITS 13
// Echoed start bit and ids followed by the five status bits
`define SCOM_UL_BITS 16

// Counter value on the last bit of each field
`define SCOM_CNT_EOF_HEAD (`SCOM_HEAD_BITS - 1)
`define SCOM_CNT_EOF_WDATA (`SCOM_CNT_EOF_HEAD + `SCOM_DATA_BITS)
`define SCOM_CNT_EOF_WPAR (`SCOM_CNT_EOF_WDATA + `SCOM_PAR_BITS)
`define SCOM_CNT_EOF_ULHEAD (`SCOM_UL_BITS - 1)
`define SCOM_CNT_RPAR_START (`SCOM_UL_BITS + `SCOM_DATA_BITS)
`define SCOM_CNT_EOF_RDATA (`SCOM_CNT_RPAR_START + `SCOM_PAR_BITS - 1)

`endif

//--- run_sim.sh
#!/bin/sh
# Builds the SCOM satellite testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_scom_satellite -f all.f -o sim_scom > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_scom > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "test failed" sim.log; then
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

//--- source/scom_bus_pkg.sv
// SCOM local register bus types
// Address, data word, data parity and acknowledge info of the register side
`include "scom_config.svh"

package scom_bus_pkg;

   typedef logic [`SCOM_REGID_BITS-1:0] reg_addr_t;

   typedef logic [`SCOM_DATA_BITS-1:0] data_word_t;

   // One bit per group of SCOM_PAR_GROUP data bits
   typedef logic [`SCOM_PAR_BITS-1:0] par_vec_t;

   // Zero means the register access completed without error
   typedef logic [1:0] ack_info_t;

endpackage

//--- source/scom_data_shifter.sv
// SCOM data shifter
// Collects write data and its parity, checks the write parity, and returns
// read data followed by generated group parity, least significant bit first
`include "scom_config.svh"

module scom_data_shifter (
   input  logic                          nclk,
   input  logic                          rst_n,
   input  scom_proto_pkg::frame_state_e  state,
   input  logic                          data_shift,
   input  logic                          par_shift,
   input  logic                          send_par,
   input  logic                          dch,
   input  logic                          sc_ack,
   input  scom_proto_pkg::cmd_e          cmd,
   input  scom_bus_pkg::data_word_t      sc_rdata,
   output scom_bus_pkg::data_word_t      sc_wdata,
   output logic                          sc_wparity,
   output logic                          wpar_err,
   output logic                          data_bit,
   output logic                          par_bit
);

   scom_bus_pkg::data_word_t  data_q;
   scom_bus_pkg::par_vec_t    par_q;
   scom_bus_pkg::par_vec_t    rpar;
   logic                      is_read;
   logic                      sending;
   logic                      data_adv;
   logic                      par_adv;

   assign is_read  = (cmd == scom_proto_pkg::CMD_READ);
   assign sending  = (state == scom_proto_pkg::SEND_RDATA);
   assign data_adv = data_shift | (sending & ~send_par);
   assign par_adv  = par_shift | send_par;

   // Parity bit i covers data bits 16i to 16i+15
   always_comb
   begin
      for (int i = 0; i < `SCOM_PAR_BITS; i++)
         rpar[i] = ^data_q[i*`SCOM_PAR_GROUP +: `SCOM_PAR_GROUP];
   end

   always_ff @(posedge nclk)
   begin
      if (state == scom_proto_pkg::EXE_CMD && sc_ack && is_read)
         data_q <= sc_rdata;
      else if (data_adv)
         data_q <= {dch & ~sending, data_q[`SCOM_DATA_BITS-1:1]};
   end

   // Received write parity is kept on writes and replaced by the
   // generated parity only on reads
   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
         par_q <= '0;
      else if (state == scom_proto_pkg::FILLER1 && is_read)
         par_q <= rpar;
      else if (par_adv)
         par_q <= {dch & ~send_par, par_q[`SCOM_PAR_BITS-1:1]};
   end

   assign sc_wdata   = data_q;
   assign sc_wparity = ^par_q;
   assign wpar_err   = ^{data_q, par_q};
   assign data_bit   = data_q[0];
   assign par_bit    = par_q[0];

endmodule

//--- source/scom_frame_ctrl.sv
// SCOM frame controller
// Sequences header reception, write data, the register access and the reply
// with a parity protected state code and a bit counter, and drives the
// registered data channel output
`include "scom_config.svh"

module scom_frame_ctrl (
   input  logic                          nclk,
   input  logic                          rst_n,
   input  logic                          active,
   input  logic                          abort,
   input  logic                          dch,
   input  logic                          cch_held,
   input  logic                          match,
   input  logic                          head_err,
   input  scom_proto_pkg::cmd_e          cmd,
   input  logic                          wpar_err,
   input  logic                          ack_err,
   input  logic                          sc_ack,
   input  logic                          ul_bit,
   input  logic                          data_bit,
   input  logic                          par_bit,
   output scom_proto_pkg::frame_state_e  state,
   output logic                          data_shift,
   output logic                          par_shift,
   output logic                          send_par,
   output logic                          sc_req,
   output logic                          dch_out,
   output logic                          state_err
);

   scom_proto_pkg::frame_state_e  state_q;
   scom_proto_pkg::frame_state_e  next_state;
   logic [`SCOM_CNT_BITS-1:0]     cnt_q;
   logic [`SCOM_CNT_BITS-1:0]     cnt_next;
   logic                          is_read;
   logic                          dch_out_next;

   assign is_read = (cmd == scom_proto_pkg::CMD_READ);

   always_comb
   begin
      next_state = state_q;
      case (state_q)
         scom_proto_pkg::IDLE:
            if (dch)
               next_state = scom_proto_pkg::REC_HEAD;
         scom_proto_pkg::REC_HEAD:
            if (cnt_q == `SCOM_CNT_EOF_HEAD)
               next_state = scom_proto_pkg::CHECK_BEFORE;
         scom_proto_pkg::CHECK_BEFORE:
            if (!match)
               next_state = scom_proto_pkg::NOT_SELECTED;
            else if (is_read && head_err)
               next_state = scom_proto_pkg::FILLER0;
            else if (is_read)
               next_state = scom_proto_pkg::EXE_CMD;
            else
               next_state = scom_proto_pkg::REC_WDATA;
         scom_proto_pkg::REC_WDATA:
            if (cnt_q == `SCOM_CNT_EOF_WDATA)
               next_state = scom_proto_pkg::REC_WPAR;
         scom_proto_pkg::REC_WPAR:
            if (cnt_q == `SCOM_CNT_EOF_WPAR)
               next_state = head_err ? scom_proto_pkg::FILLER0 : scom_proto_pkg::CHECK_WPAR;
         scom_proto_pkg::CHECK_WPAR:
            next_state = wpar_err ? scom_proto_pkg::FILLER1 : scom_proto_pkg::EXE_CMD;
         scom_proto_pkg::EXE_CMD:
            if (sc_ack)
               next_state = scom_proto_pkg::FILLER1;
         scom_proto_pkg::FILLER0:
            next_state = scom_proto_pkg::FILLER1;
         scom_proto_pkg::FILLER1:
            next_state = scom_proto_pkg::GEN_ULINFO;
         scom_proto_pkg::GEN_ULINFO:
            next_state = scom_proto_pkg::SEND_ULINFO;
         scom_proto_pkg::SEND_ULINFO:
            // Read data follows only a clean read
            if (cnt_q == `SCOM_CNT_EOF_ULHEAD)
               next_state = (is_read && !ack_err && !head_err) ? scom_proto_pkg::SEND_RDATA
                                                                : scom_proto_pkg::SEND_0;
         scom_proto_pkg::SEND_RDATA:
            if (cnt_q == `SCOM_CNT_EOF_RDATA)
               next_state = scom_proto_pkg::SEND_0;
         scom_proto_pkg::SEND_0:
            next_state = scom_proto_pkg::SEND_1;
         scom_proto_pkg::SEND_1:
            next_state = scom_proto_pkg::IDLE;
         scom_proto_pkg::NOT_SELECTED:
            if (!cch_held)
               next_state = scom_proto_pkg::IDLE;
         default:
            next_state = scom_proto_pkg::IDLE;
      endcase
   end

   // The counter holds the index of the frame bit currently on dch
   always_comb
   begin
      case (state_q)
         scom_proto_pkg::IDLE:
            cnt_next = {{(`SCOM_CNT_BITS-1){1'b0}}, dch};
         scom_proto_pkg::GEN_ULINFO:
            cnt_next = '0;
         scom_proto_pkg::REC_HEAD,
         scom_proto_pkg::CHECK_BEFORE,
         scom_proto_pkg::REC_WDATA,
         scom_proto_pkg::REC_WPAR,
         scom_proto_pkg::SEND_ULINFO:
            cnt_next = cnt_q + 1'b1;
         scom_proto_pkg::SEND_RDATA:
            // Stops on the last read parity bit
            if (cnt_q != `SCOM_CNT_EOF_RDATA)
               cnt_next = cnt_q + 1'b1;
            else
               cnt_next = cnt_q;
         default:
            cnt_next = cnt_q;
      endcase
   end

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= scom_proto_pkg::IDLE;
         cnt_q   <= '0;
      end
      else if (active)
      begin
         state_q <= abort ? scom_proto_pkg::IDLE : next_state;
         cnt_q   <= abort ? '0 : cnt_next;
      end
   end

   assign send_par = (state_q == scom_proto_pkg::SEND_RDATA) && (cnt_q >= `SCOM_CNT_RPAR_START);

   assign dch_out_next = (state_q == scom_proto_pkg::SEND_ULINFO) ? ul_bit :
                         (state_q == scom_proto_pkg::SEND_0)      ? 1'b0 :
                         (state_q == scom_proto_pkg::SEND_1)      ? 1'b1 :
                         (state_q == scom_proto_pkg::SEND_RDATA)  ? (send_par ? par_bit : data_bit) :
                         dch;

   // Not gated by active so that the ring keeps forwarding
   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
         dch_out <= 1'b0;
      else
         dch_out <= dch_out_next;
   end

   assign state      = state_q;
   assign sc_req     = (state_q == scom_proto_pkg::EXE_CMD);
   assign data_shift = (state_q == scom_proto_pkg::CHECK_BEFORE) ||
                       (state_q == scom_proto_pkg::REC_WDATA);
   assign par_shift  = (state_q == scom_proto_pkg::REC_WPAR);
   assign state_err  = ^state_q;

   a_req_release: assert property (@(posedge nclk) disable iff (!rst_n)
      $fell(sc_req) |-> $past(sc_ack || abort));

   a_cnt_range: assert property (@(posedge nclk) disable iff (!rst_n)
      cnt_q <= `SCOM_CNT_EOF_RDATA);

endmodule

//--- source/scom_head_shifter.sv
// SCOM header shifter
// Captures the frame header, matches the satellite id, checks header parity
// and shifts the echoed header and status bits back out for the reply
`include "scom_config.svh"

module scom_head_shifter (
   input  logic                          nclk,
   input  logic                          rst_n,
   input  scom_proto_pkg::frame_state_e  state,
   input  logic                          dch,
   input  scom_proto_pkg::sat_id_t       sat_id,
   input  logic                          wpar_err,
   input  logic                          sc_ack,
   input  scom_bus_pkg::ack_info_t       sc_ack_info,
   output logic                          match,
   output logic                          head_err,
   output scom_proto_pkg::cmd_e          cmd,
   output scom_bus_pkg::reg_addr_t       sc_addr,
   output logic                          ack_err,
   output logic                          ul_bit
);

   scom_proto_pkg::head_t    head_q;
   scom_proto_pkg::tail_t    tail_q;
   scom_bus_pkg::ack_info_t  ack_q;
   logic                     head_bad_q;
   logic                     par_now;
   logic [3:0]               status;

   // Start bit sits at the top, then satellite id, register id, r/nw, parity
   assign match   = (head_q[`SCOM_HEAD_BITS-2 -: `SCOM_SATID_BITS] == sat_id);
   assign sc_addr = head_q[`SCOM_REGID_BITS+1:2];
   assign cmd     = scom_proto_pkg::cmd_e'(head_q[1]);
   assign par_now = ^head_q[`SCOM_HEAD_BITS-2:0];

   assign head_err = (state == scom_proto_pkg::CHECK_BEFORE) ? par_now : head_bad_q;
   assign ack_err  = |ack_q;
   assign ul_bit   = head_q[`SCOM_HEAD_BITS-1];

   // Ack info goes out least significant bit first
   assign status = {ack_q, wpar_err & (cmd == scom_proto_pkg::CMD_WRITE), ~head_bad_q};

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q     <= '0;
         tail_q     <= '0;
         ack_q      <= '0;
         head_bad_q <= 1'b0;
      end
      else
      begin
         if ((state == scom_proto_pkg::IDLE && dch) || state == scom_proto_pkg::REC_HEAD)
            head_q <= {head_q[`SCOM_HEAD_BITS-2:0], dch};
         else if (state == scom_proto_pkg::SEND_ULINFO)
            head_q <= {head_q[`SCOM_HEAD_BITS-2:2], tail_q[0], head_q[1:0]};

         if (state == scom_proto_pkg::GEN_ULINFO)
            tail_q <= {^{sat_id, sc_addr, status}, status};
         else if (state == scom_proto_pkg::SEND_ULINFO)
            tail_q <= tail_q >> 1;

         if (state == scom_proto_pkg::EXE_CMD && sc_ack)
            ack_q <= sc_ack_info;
         else if (state == scom_proto_pkg::IDLE)
            ack_q <= '0;

         if (state == scom_proto_pkg::CHECK_BEFORE)
            head_bad_q <= par_now;
         else if (state == scom_proto_pkg::IDLE)
            head_bad_q <= 1'b0;
      end
   end

   // Latched ack info lives only from the acknowledge to the end of a reply
   // that carries no read data
   a_ack_after_exe: assert property (@(posedge nclk) disable iff (!rst_n)
      (ack_q != '0) |-> (state inside {scom_proto_pkg::FILLER1, scom_proto_pkg::GEN_ULINFO,
                                       scom_proto_pkg::SEND_ULINFO, scom_proto_pkg::SEND_0,
                                       scom_proto_pkg::SEND_1, scom_proto_pkg::IDLE}));

endmodule

//--- source/scom_proto_pkg.sv
// SCOM serial protocol types
// Frame states, the command bit and the header and status fields of a frame
`include "scom_config.svh"

package scom_proto_pkg;

   // Every code has even parity, so a single flipped state bit shows up
   typedef enum logic [4:0] {
      IDLE         = 5'b00000,
      REC_HEAD     = 5'b00011,
      CHECK_BEFORE = 5'b00101,
      REC_WDATA    = 5'b00110,
      REC_WPAR     = 5'b01001,
      EXE_CMD      = 5'b01010,
      FILLER0      = 5'b01100,
      FILLER1      = 5'b01111,
      GEN_ULINFO   = 5'b10001,
      SEND_ULINFO  = 5'b10010,
      SEND_RDATA   = 5'b10100,
      SEND_0       = 5'b10111,
      SEND_1       = 5'b11000,
      CHECK_WPAR   = 5'b11011,
      NOT_SELECTED = 5'b11110
   } frame_state_e;

   typedef enum logic {
      CMD_WRITE = 1'b0,
      CMD_READ  = 1'b1
   } cmd_e;

   typedef logic [`SCOM_SATID_BITS-1:0] sat_id_t;
   typedef logic [`SCOM_HEAD_BITS-1:0] head_t;
   typedef logic [`SCOM_UL_BITS-`SCOM_SATID_BITS-`SCOM_REGID_BITS-2:0] tail_t;

endpackage

//--- source/scom_satellite.sv
// SCOM ring satellite
// Receives register access frames on the serial data channel, runs them on
// the local register bus and sends the reply, forwarding the ring otherwise

module scom_satellite (
   input  logic                       nclk,
   input  logic                       rst_n,
   input  scom_proto_pkg::sat_id_t    sat_id,
   input  logic                       scom_dch_in,
   input  logic                       scom_cch_in,
   input  logic                       sc_ack,
   input  scom_bus_pkg::ack_info_t    sc_ack_info,
   input  scom_bus_pkg::data_word_t   sc_rdata,
   input  logic                       fsm_reset,
   output logic                       scom_dch_out,
   output logic                       scom_cch_out,
   output logic                       sc_req,
   output logic                       sc_r_nw,
   output scom_bus_pkg::reg_addr_t    sc_addr,
   output scom_bus_pkg::data_word_t   sc_wdata,
   output logic                       sc_wparity,
   output logic                       scom_err
);

   scom_proto_pkg::frame_state_e  state;
   scom_proto_pkg::cmd_e          cmd;
   logic                          dch_q;
   logic [1:0]                    cch_q;
   logic                          err_q;
   logic                          active;
   logic                          abort;
   logic                          data_shift;
   logic                          par_shift;
   logic                          send_par;
   logic                          match;
   logic                          head_err;
   logic                          ack_err;
   logic                          ul_bit;
   logic                          wpar_err;
   logic                          data_bit;
   logic                          par_bit;
   logic                          state_err;

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dch_q <= 1'b0;
         cch_q <= '0;
         err_q <= 1'b0;
      end
      else
      begin
         dch_q <= scom_dch_in;
         cch_q <= {cch_q[0], scom_cch_in};
         // Sticky until reset
         err_q <= err_q | state_err;
      end
   end

   // The FSM only runs while the control line or its recent copies are high
   assign active = scom_cch_in | (|cch_q);
   assign abort  = (cch_q[0] & ~scom_cch_in) | fsm_reset | err_q;

   assign scom_cch_out = cch_q[0];
   assign scom_err     = err_q;
   assign sc_r_nw      = (cmd == scom_proto_pkg::CMD_READ);

   scom_frame_ctrl u_frame_ctrl (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .active     (active),
      .abort      (abort),
      .dch        (dch_q),
      .cch_held   (cch_q[0]),
      .match      (match),
      .head_err   (head_err),
      .cmd        (cmd),
      .wpar_err   (wpar_err),
      .ack_err    (ack_err),
      .sc_ack     (sc_ack),
      .ul_bit     (ul_bit),
      .data_bit   (data_bit),
      .par_bit    (par_bit),
      .state      (state),
      .data_shift (data_shift),
      .par_shift  (par_shift),
      .send_par   (send_par),
      .sc_req     (sc_req),
      .dch_out    (scom_dch_out),
      .state_err  (state_err)
   );

   scom_head_shifter u_head_shifter (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .state       (state),
      .dch         (dch_q),
      .sat_id      (sat_id),
      .wpar_err    (wpar_err),
      .sc_ack      (sc_ack),
      .sc_ack_info (sc_ack_info),
      .match       (match),
      .head_err    (head_err),
      .cmd         (cmd),
      .sc_addr     (sc_addr),
      .ack_err     (ack_err),
      .ul_bit      (ul_bit)
   );

   scom_data_shifter u_data_shifter (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .state      (state),
      .data_shift (data_shift),
      .par_shift  (par_shift),
      .send_par   (send_par),
      .dch        (dch_q),
      .sc_ack     (sc_ack),
      .cmd        (cmd),
      .sc_rdata   (sc_rdata),
      .sc_wdata   (sc_wdata),
      .sc_wparity (sc_wparity),
      .wpar_err   (wpar_err),
      .data_bit   (data_bit),
      .par_bit    (par_bit)
   );

endmodule

//--- verif/scom_clk_gen.sv
// SCOM testbench clock and reset
// Free running clock with a 40 unit period and an active low reset held
// for the first 8 cycles
module scom_clk_gen (
   output logic nclk,
   output logic rst_n
);

   localparam int half_period  = 20;
   localparam int reset_cycles = 8;

   initial
   begin
      nclk = 1'b0;
      forever #half_period nclk = ~nclk;
   end

   // Release on a falling edge, away from the DUT's sampling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge nclk);
      @(negedge nclk);
      rst_n = 1'b1;
   end

endmodule

//--- verif/tb_scom_satellite.sv
// SCOM satellite testbench
// Sends directed frames on the data channel, answers the register side and
// checks the uplink reply bit by bit against the frame rules
`include "scom_config.svh"

module tb_scom_satellite;

   localparam int timeout_cycles = 200;
   localparam scom_proto_pkg::sat_id_t own_id = 4'ha;

   logic                      nclk;
   logic                      rst_n;
   scom_proto_pkg::sat_id_t   sat_id;
   logic                      scom_dch_in;
   logic                      scom_cch_in;
   logic                      sc_ack;
   scom_bus_pkg::ack_info_t   sc_ack_info;
   scom_bus_pkg::data_word_t  sc_rdata;
   logic                      fsm_reset;
   logic                      scom_dch_out;
   logic                      scom_cch_out;
   logic                      sc_req;
   logic                      sc_r_nw;
   scom_bus_pkg::reg_addr_t   sc_addr;
   scom_bus_pkg::data_word_t  sc_wdata;
   logic                      sc_wparity;
   logic                      scom_err;

   logic [31:0]  rng_state;
   int           err_cnt;
   int           chk_cnt;
   logic         frame_q[$];
   logic         exp_q[$];

   scom_clk_gen clk_gen0 (
      .nclk  (nclk),
      .rst_n (rst_n)
   );

   scom_satellite dut0 (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .sat_id       (sat_id),
      .scom_dch_in  (scom_dch_in),
      .scom_cch_in  (scom_cch_in),
      .sc_ack       (sc_ack),
      .sc_ack_info  (sc_ack_info),
      .sc_rdata     (sc_rdata),
      .fsm_reset    (fsm_reset),
      .scom_dch_out (scom_dch_out),
      .scom_cch_out (scom_cch_out),
      .sc_req       (sc_req),
      .sc_r_nw      (sc_r_nw),
      .sc_addr      (sc_addr),
      .sc_wdata     (sc_wdata),
      .sc_wparity   (sc_wparity),
      .scom_err     (scom_err)
   );

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Parity bit g covers data bits 16g to 16g+15
   function automatic logic [3:0] group_parity(input logic [63:0] d);
      logic [3:0] p;
      int         g;
      for (g = 0; g < `SCOM_PAR_BITS; g++)
         p[g] = ^d[g*`SCOM_PAR_GROUP +: `SCOM_PAR_GROUP];
      return p;
   endfunction

   task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
      chk_cnt++;
      assert (got === exp)
      else
      begin
         err_cnt++;
         $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      chk_cnt++;
      assert (cond === 1'b1)
      else
      begin
         err_cnt++;
         $display("At time %0t the check failed because %s", $time, what);
      end
   endtask

   task automatic build_frame(input logic [3:0] sid, input logic [5:0] reg_id, input logic rnw,
                              input logic bad_hpar, input logic [63:0] wdata,
                              input logic bad_wpar);
      logic       hpar;
      logic [3:0] wpar;
      int         i;
      frame_q.delete();
      hpar = ^{sid, reg_id, rnw} ^ bad_hpar;
      wpar = group_parity(wdata);
      wpar[0] = wpar[0] ^ bad_wpar;
      frame_q.push_back(1'b1);
      for (i = `SCOM_SATID_BITS - 1; i >= 0; i--)
         frame_q.push_back(sid[i]);
      for (i = `SCOM_REGID_BITS - 1; i >= 0; i--)
         frame_q.push_back(reg_id[i]);
      frame_q.push_back(rnw);
      frame_q.push_back(hpar);
      if (!rnw)
      begin
         for (i = 0; i < `SCOM_DATA_BITS; i++)
            frame_q.push_back(wdata[i]);
         for (i = 0; i < `SCOM_PAR_BITS; i++)
            frame_q.push_back(wpar[i]);
      end
   endtask

   task automatic build_reply(input logic [3:0] sid, input logic [5:0] reg_id, input logic rnw,
                              input logic hbad, input logic wbad, input logic [1:0] ack,
                              input logic [63:0] rdata);
      logic [4:0] st;
      logic [3:0] rpar;
      int         i;
      exp_q.delete();
      st[0] = ~hbad;
      st[1] = wbad;
      st[3:2] = ack;
      st[4] = ^{sid, reg_id, st[3:0]};
      rpar = group_parity(rdata);
      exp_q.push_back(1'b1);
      for (i = `SCOM_SATID_BITS - 1; i >= 0; i--)
         exp_q.push_back(sid[i]);
      for (i = `SCOM_REGID_BITS - 1; i >= 0; i--)
         exp_q.push_back(reg_id[i]);
      for (i = 0; i < 5; i++)
         exp_q.push_back(st[i]);
      // Data and its group parity only follow a clean read
      if (rnw && ack == 2'b00 && !hbad)
      begin
         for (i = 0; i < `SCOM_DATA_BITS; i++)
            exp_q.push_back(rdata[i]);
         for (i = 0; i < `SCOM_PAR_BITS; i++)
            exp_q.push_back(rpar[i]);
      end
      exp_q.push_back(1'b0);
      exp_q.push_back(1'b1);
   endtask

   task automatic open_window();
      @(negedge nclk);
      scom_cch_in = 1'b1;
   endtask

   task automatic close_window();
      @(negedge nclk);
      scom_cch_in = 1'b0;
      repeat (4) @(negedge nclk);
   endtask

   task automatic send_frame();
      int i;
      for (i = 0; i < frame_q.size(); i++)
      begin
         @(negedge nclk);
         scom_dch_in = frame_q[i];
      end
      @(negedge nclk);
      scom_dch_in = 1'b0;
   endtask

   task automatic serve_request(input logic [5:0] exp_addr, input logic exp_rnw,
                                input logic [63:0] exp_wdata, input logic [1:0] ack_info,
                                input logic [63:0] rdata, input int delay);
      int n;
      int i;
      n = 0;
      while (sc_req !== 1'b1 && n < timeout_cycles)
      begin
         @(negedge nclk);
         n++;
      end
      check_true(sc_req === 1'b1, "sc_req never rose after a selected frame");
      if (sc_req !== 1'b1)
         return;
      check_val(sc_addr, exp_addr, "sc_addr");
      check_val(sc_r_nw, exp_rnw, "sc_r_nw");
      if (!exp_rnw)
      begin
         check_val(sc_wdata, exp_wdata, "sc_wdata");
         check_val(sc_wparity, ^group_parity(exp_wdata), "sc_wparity");
      end
      for (i = 0; i < delay; i++)
      begin
         @(negedge nclk);
         check_val(sc_req, 1'b1, "sc_req while waiting for ack");
         check_val(sc_addr, exp_addr, "sc_addr while waiting for ack");
      end
      sc_ack = 1'b1;
      sc_ack_info = ack_info;
      sc_rdata = rdata;
      @(negedge nclk);
      sc_ack = 1'b0;
      sc_ack_info = '0;
      check_val(sc_req, 1'b0, "sc_req after ack");
   endtask

   // Skips the forwarded copy of the frame before looking for the start bit
   task automatic find_reply(output logic found);
      int n;
      repeat (2) @(negedge nclk);
      n = 0;
      while (scom_dch_out !== 1'b1 && n < timeout_cycles)
      begin
         check_val(sc_req, 1'b0, "sc_req outside the register access");
         @(negedge nclk);
         n++;
      end
      found = (scom_dch_out === 1'b1);
      check_true(found, "no reply start bit appeared on scom_dch_out");
   endtask

   task automatic check_reply();
      logic found;
      int   i;
      find_reply(found);
      if (found)
      begin
         for (i = 0; i < exp_q.size(); i++)
         begin
            if (i > 0)
               @(negedge nclk);
            check_val(scom_dch_out, exp_q[i], $sformatf("reply bit %0d", i));
         end
         @(negedge nclk);
         check_val(scom_dch_out, 1'b0, "scom_dch_out after the reply");
      end
   endtask

   task automatic test_write();
      logic [63:0] wdata;
      wdata[63:32] = lcg_next();
      wdata[31:0] = lcg_next();
      build_frame(own_id, 6'h2d, 1'b0, 1'b0, wdata, 1'b0);
      build_reply(own_id, 6'h2d, 1'b0, 1'b0, 1'b0, 2'b10, '0);
      open_window();
      send_frame();
      serve_request(6'h2d, 1'b0, wdata, 2'b10, '0, 1);
      check_reply();
      close_window();
   endtask

   task automatic test_read();
      logic [63:0] rdata;
      int          delay;
      rdata[63:32] = lcg_next();
      rdata[31:0] = lcg_next();
      delay = int'(lcg_next() % 32'd6);
      build_frame(own_id, 6'h13, 1'b1, 1'b0, '0, 1'b0);
      build_reply(own_id, 6'h13, 1'b1, 1'b0, 1'b0, 2'b00, rdata);
      open_window();
      send_frame();
      serve_request(6'h13, 1'b1, '0, 2'b00, rdata, delay);
      check_reply();
      close_window();
   endtask

   task automatic test_bad_head_parity();
      build_frame(own_id, 6'h05, 1'b1, 1'b1, '0, 1'b0);
      build_reply(own_id, 6'h05, 1'b1, 1'b1, 1'b0, 2'b00, '0);
      open_window();
      send_frame();
      check_reply();
      close_window();
   endtask

   task automatic test_bad_write_parity();
      logic [63:0] wdata;
      wdata[63:32] = lcg_next();
      wdata[31:0] = lcg_next();
      build_frame(own_id, 6'h3a, 1'b0, 1'b0, wdata, 1'b1);
      build_reply(own_id, 6'h3a, 1'b0, 1'b0, 1'b1, 2'b00, '0);
      open_window();
      send_frame();
      check_reply();
      close_window();
   endtask

   // Another node's frame must pass straight through with no register access
   task automatic test_other_satellite();
      logic        dch_seq[$];
      logic        cch_seq[$];
      logic [63:0] wdata;
      int          k;
      wdata[63:32] = lcg_next();
      wdata[31:0] = lcg_next();
      build_frame(own_id ^ 4'h5, 6'h11, 1'b0, 1'b0, wdata, 1'b0);
      for (k = 0; k < 2; k++)
      begin
         dch_seq.push_back(1'b0);
         cch_seq.push_back(1'b1);
      end
      for (k = 0; k < frame_q.size(); k++)
      begin
         dch_seq.push_back(frame_q[k]);
         cch_seq.push_back(1'b1);
      end
      for (k = 0; k < 10; k++)
      begin
         dch_seq.push_back(1'b0);
         cch_seq.push_back(k < 6);
      end
      for (k = 0; k < dch_seq.size(); k++)
      begin
         @(negedge nclk);
         if (k >= 2)
            check_val(scom_dch_out, dch_seq[k-2], $sformatf("forwarded dch step %0d", k));
         if (k >= 1)
            check_val(scom_cch_out, cch_seq[k-1], $sformatf("forwarded cch step %0d", k));
         check_val(sc_req, 1'b0, "sc_req for another satellite");
         scom_dch_in = dch_seq[k];
         scom_cch_in = cch_seq[k];
      end
   endtask

   task automatic test_read_ack_error();
      logic [63:0] rdata;
      int          delay;
      rdata[63:32] = lcg_next();
      rdata[31:0] = lcg_next();
      delay = int'(lcg_next() % 32'd6);
      build_frame(own_id, 6'h27, 1'b1, 1'b0, '0, 1'b0);
      build_reply(own_id, 6'h27, 1'b1, 1'b0, 1'b0, 2'b11, rdata);
      open_window();
      send_frame();
      serve_request(6'h27, 1'b1, '0, 2'b11, rdata, delay);
      check_reply();
      close_window();
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (rst_n !== 1'b1 && n < 20)
      begin
         @(negedge nclk);
         n++;
      end
      check_true(rst_n === 1'b1, "reset was never released");
      @(negedge nclk);
   endtask

   initial
   begin
      rng_state = 32'hc68;
      err_cnt = 0;
      chk_cnt = 0;
      sat_id = own_id;
      scom_dch_in = 1'b0;
      scom_cch_in = 1'b0;
      sc_ack = 1'b0;
      sc_ack_info = '0;
      sc_rdata = '0;
      fsm_reset = 1'b0;
      wait_reset();
      check_val(sc_req, 1'b0, "sc_req after reset");
      check_val(scom_err, 1'b0, "scom_err after reset");
      check_val(scom_dch_out, 1'b0, "scom_dch_out after reset");
      check_val(scom_cch_out, 1'b0, "scom_cch_out after reset");
      test_write();
      test_read();
      test_bad_head_parity();
      test_bad_write_parity();
      test_other_satellite();
      test_read_ack_error();
      check_val(scom_err, 1'b0, "scom_err at end of run");
      $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
